// ==== Bender.yml ====
package:
  name: stack_soc

sources:
  - include_dirs:
      - common
    files:
      - common/stack_cpu_pkg.sv
      - common/data_bus_if.sv
      - src/stack_cpu.sv
      - src/uart/uart_tx.sv
      - src/uart/uart_rx.sv
      - src/io_map.sv
      - src/stack_soc_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - verification/stack_soc_tb.sv

// ==== all.f ====
+incdir+common
common/stack_cpu_pkg.sv
common/data_bus_if.sv
src/stack_cpu.sv
src/uart/uart_tx.sv
src/uart/uart_rx.sv
src/io_map.sv
src/stack_soc_top.sv
verification/stack_soc_tb.sv

// ==== common/data_bus_if.sv ====
`include "stack_cpu_defines.svh"

// cpu data bus with plain one-cycle strobes
interface data_bus_if;

  // address straight from the alu
  logic [`DATA_W-1:0] addr;
  // strobes high during phase 2 only
  logic               rd;
  logic               wr;
  logic [`DATA_W-1:0] wr_data;
  // registered copy of the addressed location
  logic [`DATA_W-1:0] rd_data;

  modport cpu (
    output addr, rd, wr, wr_data,
    input  rd_data
  );

  modport mem (
    input  addr, rd, wr, wr_data,
    output rd_data
  );

endinterface

// ==== common/stack_cpu_defines.svh ====
`ifndef STACK_CPU_DEFINES_SVH
`define STACK_CPU_DEFINES_SVH

// datapath widths
`define DATA_W 8
`define PC_W 10
`define INSN_W 16

// operand stack entries
`define STACK_DEPTH 8

// fetching this word freezes the pc
`define HALT_INSN 16'hFFFF

// memory map
`define ADDR_UART_DATA 8'h01
`define ADDR_TX_BUSY 8'h02
`define ADDR_RX_EMPTY 8'h03
`define RAM_BASE 8'h20

// clocks per uart bit
`define UART_BIT_CLKS 8

`endif

// ==== common/stack_cpu_pkg.sv ====
`include "stack_cpu_defines.svh"

package stack_cpu_pkg;

  // alu function codes carried in the low instruction byte
  typedef enum logic [`DATA_W-1:0] {
    // pass stack 0
    alu_top  = 8'h00,
    // pass stack 1
    alu_next = 8'h01,
    alu_add  = 8'h02,
    // stack 0 minus stack 1
    alu_sub  = 8'h03,
    // low byte of the product
    alu_mul  = 8'h04,
    // unsigned compare, result 0 or 1
    alu_lt   = 8'h08
  } alu_fn_e;

  // source of the new top of stack
  typedef enum logic [1:0] {
    load_keep = 2'd0,
    load_next = 2'd1,
    load_alu  = 2'd2,
    load_mem  = 2'd3
  } load_sel_e;

  // low byte is an immediate when imm is set, else an alu function
  typedef union packed {
    logic [`DATA_W-1:0] imm8;
    alu_fn_e            fn;
  } operand_u;

  // 16-bit instruction word, msb first
  typedef struct packed {
    logic      imm;
    logic      jz;
    load_sel_e load;
    logic      rd;
    logic      wr;
    logic      pop;
    logic      push;
    operand_u  operand;
  } insn_t;

endpackage

// ==== src/io_map.sv ====
`include "stack_cpu_defines.svh"

module io_map (
  input  logic               clk,
  input  logic               rst,
  data_bus_if.mem            bus,
  output logic               tx_start,
  output logic [`DATA_W-1:0] tx_data,
  input  logic               tx_busy,
  input  logic [`DATA_W-1:0] rx_data,
  input  logic               rx_valid,
  output logic               rx_clear
);

  // general ram covers the top of the byte space
  logic [`DATA_W-1:0] ram [`RAM_BASE:(1 << `DATA_W) - 1];
  logic               is_ram;
  logic               is_uart;
  logic               is_tx_busy;
  logic               is_rx_empty;
  logic [`DATA_W-1:0] rd_next;

  // address decode
  // 00h and the unused reserved words fall through to zero
  assign is_ram      = (bus.addr >= `RAM_BASE);
  assign is_uart     = (bus.addr == `ADDR_UART_DATA);
  assign is_tx_busy  = (bus.addr == `ADDR_TX_BUSY);
  assign is_rx_empty = (bus.addr == `ADDR_RX_EMPTY);

  // uart side effects
  // writes while the transmitter is busy are dropped
  assign tx_start = bus.wr && is_uart && !tx_busy;
  assign tx_data  = bus.wr_data;
  // reading the data port consumes the byte
  assign rx_clear = bus.rd && is_uart;

  // read mux
  always_comb begin
    rd_next = '0;
    if (is_ram) begin
      rd_next = ram[bus.addr];
    end else if (is_uart) begin
      rd_next = rx_data;
    end else if (is_tx_busy) begin
      rd_next = {{(`DATA_W-1){1'b0}}, tx_busy};
    end else if (is_rx_empty) begin
      rd_next = {{(`DATA_W-1){1'b0}}, !rx_valid};
    end
  end

  // read data follows the address one cycle later
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bus.rd_data <= '0;
    end else begin
      bus.rd_data <= rd_next;
    end
  end

  // ram write port
  always_ff @(posedge clk) begin
    if (bus.wr && is_ram) begin
      ram[bus.addr] <= bus.wr_data;
    end
  end

endmodule

// ==== src/stack_cpu.sv ====
`include "stack_cpu_defines.svh"

module stack_cpu (
  input  logic                 clk,
  input  logic                 rst,
  input  stack_cpu_pkg::insn_t insn,
  output logic [`PC_W-1:0]     pc,
  data_bus_if.cpu              bus
);

  // four phases per instruction
  // 0 execute, 1 address, 2 bus access, 3 stack writeback
  logic [1:0]         phase;
  logic [`DATA_W-1:0] stack [`STACK_DEPTH];
  logic [`DATA_W-1:0] alu_out;
  logic [`DATA_W-1:0] new_top;
  logic               halt;

  assign halt = (insn == `HALT_INSN);

  // alu
  always_comb begin
    if (insn.imm) begin
      // immediate passes straight through
      alu_out = insn.operand.imm8;
    end else begin
      case (insn.operand.fn)
        stack_cpu_pkg::alu_top:  alu_out = stack[0];
        stack_cpu_pkg::alu_next: alu_out = stack[1];
        stack_cpu_pkg::alu_add:  alu_out = stack[0] + stack[1];
        stack_cpu_pkg::alu_sub:  alu_out = stack[0] - stack[1];
        // truncated to the low byte
        stack_cpu_pkg::alu_mul:  alu_out = stack[0] * stack[1];
        stack_cpu_pkg::alu_lt:   alu_out = {{(`DATA_W-1){1'b0}}, stack[0] < stack[1]};
        default:                 alu_out = '0;
      endcase
    end
  end

  // alu result doubles as the bus address
  assign bus.addr = alu_out;

  // new top of stack
  always_comb begin
    case (insn.load)
      stack_cpu_pkg::load_keep: new_top = stack[0];
      stack_cpu_pkg::load_next: new_top = stack[1];
      stack_cpu_pkg::load_alu:  new_top = alu_out;
      default:                  new_top = bus.rd_data;
    endcase
  end

  // phase counter wraps every four cycles
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase <= 2'd0;
    end else begin
      phase <= phase + 2'd1;
    end
  end

  // operand stack, written at the end of phase 3
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `STACK_DEPTH; i++) begin
        stack[i] <= '0;
      end
    end else if (phase == 2'd3) begin
      stack[0] <= new_top;
      if (insn.push && !insn.pop) begin
        // push shifts toward the deepest entry
        for (int i = 1; i < `STACK_DEPTH; i++) begin
          stack[i] <= stack[i-1];
        end
      end else if (insn.pop && !insn.push) begin
        // pop shifts up and leaves the deepest entry alone
        for (int i = 1; i < `STACK_DEPTH - 1; i++) begin
          stack[i] <= stack[i+1];
        end
      end
    end
  end

  // bus strobes
  // raised at the end of phase 1 so they cover phase 2 only
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bus.wr <= 1'b0;
      bus.rd <= 1'b0;
    end else begin
      bus.wr <= (phase == 2'd1) && insn.wr;
      bus.rd <= (phase == 2'd1) && insn.rd;
    end
  end

  // store data latched alongside the strobes
  // immediate stores take stack 0, indirect stores take stack 1
  always_ff @(posedge clk) begin
    if (phase == 2'd1) begin
      bus.wr_data <= insn.imm ? stack[0] : stack[1];
    end
  end

  // pc, updated at the end of phase 2
  // jump test sees the stack from before this instruction
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (phase == 2'd2 && !halt) begin
      if (insn.jz && stack[0] == '0) begin
        pc <= {{(`PC_W-`DATA_W){1'b0}}, insn.operand.imm8};
      end else begin
        pc <= pc + `PC_W'(1);
      end
    end
  end

endmodule

// ==== src/stack_soc_top.sv ====
`include "stack_cpu_defines.svh"

module stack_soc_top (
  input  logic               clk,
  input  logic               rst,
  input  logic [`INSN_W-1:0] insn,
  input  logic               uart_rxd,
  output logic [`PC_W-1:0]   pc,
  output logic               uart_txd
);

  // uart links between io_map and the serial blocks
  logic               tx_start;
  logic [`DATA_W-1:0] tx_data;
  logic               tx_busy;
  logic [`DATA_W-1:0] rx_data;
  logic               rx_valid;
  logic               rx_clear;

  data_bus_if bus ();

  // instruction word comes from the external rom
  stack_cpu u_cpu (
    .clk  (clk),
    .rst  (rst),
    .insn (stack_cpu_pkg::insn_t'(insn)),
    .pc   (pc),
    .bus  (bus.cpu)
  );

  io_map u_io_map (
    .clk      (clk),
    .rst      (rst),
    .bus      (bus.mem),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx_busy  (tx_busy),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_clear (rx_clear)
  );

  uart_tx u_uart_tx (
    .clk   (clk),
    .rst   (rst),
    .start (tx_start),
    .data  (tx_data),
    .busy  (tx_busy),
    .txd   (uart_txd)
  );

  uart_rx u_uart_rx (
    .clk   (clk),
    .rst   (rst),
    .rxd   (uart_rxd),
    .clear (rx_clear),
    .data  (rx_data),
    .valid (rx_valid)
  );

endmodule

// ==== src/uart/uart_rx.sv ====
`include "stack_cpu_defines.svh"

module uart_rx (
  input  logic               clk,
  input  logic               rst,
  input  logic               rxd,
  input  logic               clear,
  output logic [`DATA_W-1:0] data,
  output logic               valid
);

  localparam int CNT_W = $clog2(`UART_BIT_CLKS);
  localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(`UART_BIT_CLKS - 1);
  localparam logic [CNT_W-1:0] MID_CLK  = CNT_W'(`UART_BIT_CLKS / 2 - 1);

  // two-flop synchronizer plus one more for edge detect
  logic               rxd_meta;
  logic               rxd_sync;
  logic               rxd_prev;
  logic               active;
  logic [CNT_W-1:0]   clk_cnt;
  logic [3:0]         bit_cnt;
  logic [`DATA_W-1:0] shift;
  logic               sample;

  // mid-bit strobe while a frame is in progress
  assign sample = active && (clk_cnt == MID_CLK);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  // frame timing
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active  <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      valid   <= 1'b0;
    end else begin
      if (clear) begin
        valid <= 1'b0;
      end
      if (!active) begin
        // falling edge opens a frame
        if (rxd_prev && !rxd_sync) begin
          active  <= 1'b1;
          clk_cnt <= '0;
          bit_cnt <= '0;
        end
      end else begin
        clk_cnt <= (clk_cnt == LAST_CLK) ? '0 : clk_cnt + CNT_W'(1);
        if (sample) begin
          if (bit_cnt == 4'd0 && rxd_sync) begin
            // start bit gone high again, treat as a glitch
            active <= 1'b0;
          end else if (bit_cnt == 4'd9) begin
            active <= 1'b0;
            // good stop bit sets valid, even over an unread byte
            if (rxd_sync) begin
              valid <= 1'b1;
            end
          end else begin
            bit_cnt <= bit_cnt + 4'd1;
          end
        end
      end
    end
  end

  // data path
  always_ff @(posedge clk) begin
    if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
      // lsb arrives first
      shift <= {rxd_sync, shift[`DATA_W-1:1]};
    end
    if (sample && bit_cnt == 4'd9 && rxd_sync) begin
      data <= shift;
    end
  end

endmodule

// ==== src/uart/uart_tx.sv ====
`include "stack_cpu_defines.svh"

module uart_tx (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic [`DATA_W-1:0] data,
  output logic               busy,
  output logic               txd
);

  localparam int CNT_W = $clog2(`UART_BIT_CLKS);
  localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(`UART_BIT_CLKS - 1);

  // clocks within the current bit
  logic [CNT_W-1:0] clk_cnt;
  // bit index within the frame, 0 start through 9 stop
  logic [3:0]       bit_cnt;
  // frame shifts out lsb first
  logic [9:0]       shift;

  // idle shift register holds all ones so the line rests high
  assign txd = shift[0];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      shift   <= '1;
    end else if (!busy) begin
      if (start) begin
        // stop bit, data, start bit
        shift   <= {1'b1, data, 1'b0};
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (clk_cnt == LAST_CLK) begin
      clk_cnt <= '0;
      // refill with ones behind the frame
      shift   <= {1'b1, shift[9:1]};
      if (bit_cnt == 4'd9) begin
        // stop bit done
        busy <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + CNT_W'(1);
    end
  end

endmodule

// ==== verification/stack_soc_tb.sv ====
`include "stack_cpu_defines.svh"

module stack_soc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int B = `UART_BIT_CLKS;

  logic               clk;
  logic               rst;
  logic [`INSN_W-1:0] insn;
  logic               uart_rxd;
  logic [`PC_W-1:0]   pc;
  logic               uart_txd;
  logic               rxd_drive;
  stack_cpu_pkg::insn_t cur;
  // program rom, indexed by the low pc byte
  stack_cpu_pkg::insn_t rom [256];
  int                 wp;
  logic [7:0]         tx_q [$];
  logic [7:0]         exp_q [$];
  int                 value_errors;
  int                 other_errors;
  integer             seed;
  // pc checker state and stack model with known flags
  int                 ph;
  logic [7:0]         ms [8];
  logic               mk [8];
  logic [`PC_W-1:0]   pc_exp;
  logic               pc_chk;
  logic [7:0]         alu_v;
  logic [7:0]         top_v;
  logic               alu_k;
  logic               top_k;
  // tx line monitor state
  logic               mon_active;
  int                 mon_cnt;
  int                 mon_idx;
  logic [7:0]         mon_byte;
  // test data
  logic [7:0]         a;
  logic [7:0]         b;
  logic [7:0]         fns [6];
  logic [7:0]         addrs [8];
  logic [`PC_W-1:0]   halt_pc;

  stack_soc_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .insn     (insn),
    .uart_rxd (uart_rxd),
    .pc       (pc),
    .uart_txd (uart_txd)
  );

  assign cur = insn;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // rom fetch registered on pc and the serial line taken from the driver
  always @(posedge clk) begin
    insn     <= rom[pc[7:0]];
    uart_rxd <= rxd_drive;
  end

  task automatic report_mismatch(string name, int exp, int act);
    value_errors++;
    $display("FAILED t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
  endtask

  task automatic report_problem(string msg);
    other_errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // reset holds pc at zero and the line idle
  assert property (@(posedge clk) rst |-> (pc == '0 && uart_txd))
    else report_mismatch("pc/uart_txd in reset", 1, {$sampled(pc), $sampled(uart_txd)});
  assert property (@(posedge clk) $fell(rst) |-> (pc == '0 && uart_txd))
    else report_mismatch("pc/uart_txd after reset", 1, {$sampled(pc), $sampled(uart_txd)});

  // reference alu rules
  function automatic logic [7:0] alu_model(logic [7:0] fn, logic [7:0] s0, logic [7:0] s1);
    case (fn)
      stack_cpu_pkg::alu_top:  return s0;
      stack_cpu_pkg::alu_next: return s1;
      stack_cpu_pkg::alu_add:  return s0 + s1;
      stack_cpu_pkg::alu_sub:  return s0 - s1;
      stack_cpu_pkg::alu_mul:  return 8'(s0 * s1);
      stack_cpu_pkg::alu_lt:   return {7'b0, s0 < s1};
      default:                 return 8'h00;
    endcase
  endfunction

  // small assembler
  function automatic stack_cpu_pkg::insn_t make_insn(logic imm, logic jz,
      stack_cpu_pkg::load_sel_e load, logic rd, logic wr, logic pop, logic push,
      logic [7:0] op);
    stack_cpu_pkg::insn_t i;
    i = '0;
    i.imm = imm;
    i.jz = jz;
    i.load = load;
    i.rd = rd;
    i.wr = wr;
    i.pop = pop;
    i.push = push;
    i.operand.imm8 = op;
    return i;
  endfunction

  function automatic stack_cpu_pkg::insn_t push_imm(logic [7:0] v);
    return make_insn(1, 0, stack_cpu_pkg::load_alu, 0, 0, 0, 1, v);
  endfunction

  function automatic stack_cpu_pkg::insn_t alu_op(logic [7:0] fn);
    return make_insn(0, 0, stack_cpu_pkg::load_alu, 0, 0, 0, 0, fn);
  endfunction

  function automatic stack_cpu_pkg::insn_t store_top(logic [7:0] addr);
    return make_insn(1, 0, stack_cpu_pkg::load_keep, 0, 1, 0, 0, addr);
  endfunction

  function automatic stack_cpu_pkg::insn_t load_push(logic [7:0] addr);
    return make_insn(1, 0, stack_cpu_pkg::load_mem, 1, 0, 0, 1, addr);
  endfunction

  function automatic stack_cpu_pkg::insn_t jump_zero_pop(logic [7:0] target);
    return make_insn(1, 1, stack_cpu_pkg::load_next, 0, 0, 1, 0, target);
  endfunction

  task automatic emit(stack_cpu_pkg::insn_t i);
    rom[wp] = i;
    wp++;
  endtask

  // loop until the word at addr reads zero and leave the stack as before
  task automatic emit_poll_zero(logic [7:0] addr);
    int top;
    top = wp;
    emit(load_push(addr));
    emit(jump_zero_pop(8'(top + 4)));
    emit(push_imm(8'h00));
    emit(jump_zero_pop(8'(top)));
  endtask

  task automatic emit_send_top();
    emit_poll_zero(`ADDR_TX_BUSY);
    emit(store_top(`ADDR_UART_DATA));
  endtask

  // cpu held in reset while the rom is rewritten
  task automatic hold_reset();
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < 256; i++) begin
      rom[i] = `HALT_INSN;
    end
    wp = 0;
    tx_q.delete();
    exp_q.delete();
  endtask

  task automatic release_reset();
    repeat (7) @(posedge clk);
    rst <= 1'b0;
  endtask

  // frame on uart_rxd with the lsb first
  task automatic send_byte(logic [7:0] v);
    logic [9:0] frame;
    frame = {1'b1, v, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd_drive <= frame[i];
      repeat (B) @(posedge clk);
    end
  endtask

  task automatic wait_halt();
    int n;
    n = 0;
    while (insn !== `HALT_INSN && n < 20000) begin
      @(posedge clk);
      n++;
    end
    if (n >= 20000) begin
      report_problem("timeout waiting for the halt instruction");
    end
    halt_pc = pc;
    for (int i = 0; i < 40; i++) begin
      @(posedge clk);
      assert (pc == halt_pc) else report_mismatch("pc after halt", halt_pc, pc);
    end
  endtask

  task automatic check_frames();
    int n;
    logic [7:0] e;
    logic [7:0] g;
    n = 0;
    while (tx_q.size() < exp_q.size() && n < 2000) begin
      @(posedge clk);
      n++;
    end
    if (n >= 2000) begin
      report_problem("timeout waiting for transmitted frames");
    end
    while (exp_q.size() > 0 && tx_q.size() > 0) begin
      e = exp_q.pop_front();
      g = tx_q.pop_front();
      assert (g == e) else report_mismatch("uart_txd byte", e, g);
    end
    if (tx_q.size() != 0) begin
      report_problem("more frames than expected on uart_txd");
    end
  endtask

  // model the stack at the end of phase 3
  task automatic update_model();
    if (cur.imm) begin
      alu_v = cur.operand.imm8;
      alu_k = 1'b1;
    end else begin
      alu_v = alu_model(cur.operand.imm8, ms[0], ms[1]);
      alu_k = mk[0] && mk[1];
    end
    case (cur.load)
      stack_cpu_pkg::load_keep: begin
        top_v = ms[0];
        top_k = mk[0];
      end
      stack_cpu_pkg::load_next: begin
        top_v = ms[1];
        top_k = mk[1];
      end
      stack_cpu_pkg::load_alu: begin
        top_v = alu_v;
        top_k = alu_k;
      end
      default: begin
        top_v = 8'h00;
        top_k = 1'b0;
      end
    endcase
    if (cur.push && !cur.pop) begin
      for (int i = 7; i >= 1; i--) begin
        ms[i] = ms[i-1];
        mk[i] = mk[i-1];
      end
    end else if (cur.pop && !cur.push) begin
      for (int i = 1; i < 7; i++) begin
        ms[i] = ms[i+1];
        mk[i] = mk[i+1];
      end
    end
    ms[0] = top_v;
    mk[0] = top_k;
  endtask

  // pc may move only at the end of phase 2
  always @(posedge clk) begin
    if (rst) begin
      ph = 0;
      pc_chk = 1'b0;
      for (int i = 0; i < 8; i++) begin
        ms[i] = 8'h00;
        mk[i] = 1'b1;
      end
    end else begin
      if (pc_chk) begin
        assert (pc == pc_exp) else report_mismatch("pc", pc_exp, pc);
      end
      pc_exp = pc;
      pc_chk = 1'b1;
      if (ph == 2 && insn !== `HALT_INSN) begin
        if (!cur.jz) begin
          pc_exp = pc + 1'b1;
        end else if (!mk[0]) begin
          // no prediction for a jump on a value read from the bus
          pc_chk = 1'b0;
        end else begin
          pc_exp = (ms[0] == 8'h00) ? {2'b00, cur.operand.imm8} : pc + 1'b1;
        end
      end
      if (ph == 3) begin
        update_model();
      end
      ph = (ph + 1) % 4;
    end
  end

  // tx frame decoder sampling mid-bit
  always @(posedge clk) begin
    if (rst) begin
      mon_active = 1'b0;
    end else if (!mon_active) begin
      if (!uart_txd) begin
        mon_active = 1'b1;
        mon_cnt = 0;
      end
    end else begin
      mon_cnt++;
      if (mon_cnt >= B / 2 && (mon_cnt - B / 2) % B == 0) begin
        mon_idx = (mon_cnt - B / 2) / B;
        if (mon_idx == 0 && uart_txd) begin
          report_problem("start bit on uart_txd did not hold low");
          mon_active = 1'b0;
        end else if (mon_idx >= 1 && mon_idx <= 8) begin
          mon_byte[mon_idx-1] = uart_txd;
        end else if (mon_idx == 9) begin
          if (!uart_txd) begin
            report_problem("missing stop bit on uart_txd");
          end else begin
            tx_q.push_back(mon_byte);
          end
          mon_active = 1'b0;
        end
      end
    end
  end

  initial begin
    rst = 1'b1;
    insn = `HALT_INSN;
    uart_rxd = 1'b1;
    rxd_drive = 1'b1;
    value_errors = 0;
    other_errors = 0;
    seed = 32'h2d3a237a;
    fns = '{stack_cpu_pkg::alu_add, stack_cpu_pkg::alu_sub, stack_cpu_pkg::alu_mul,
            stack_cpu_pkg::alu_lt, stack_cpu_pkg::alu_top, stack_cpu_pkg::alu_next};
    addrs = '{8'h20, 8'h21, 8'h7F, 8'hA5, 8'hFF, 8'h00, 8'h05, 8'h1F};

    // alu and stack with random operand pairs
    hold_reset();
    for (int p = 0; p < 3; p++) begin
      a = $random(seed);
      b = $random(seed);
      for (int f = 0; f < 6; f++) begin
        emit(push_imm(a));
        emit(push_imm(b));
        emit(alu_op(fns[f]));
        emit_send_top();
        // b on top and a below
        exp_q.push_back(alu_model(fns[f], b, a));
      end
    end
    release_reset();
    wait_halt();
    check_frames();

    // jumps taken and not taken
    hold_reset();
    emit(push_imm(8'h00));
    emit(jump_zero_pop(8'd5));
    wp = 5;
    emit(push_imm(8'h06));
    emit(jump_zero_pop(8'd0));
    emit(push_imm(8'h03));
    emit(push_imm(8'h03));
    emit(alu_op(stack_cpu_pkg::alu_sub));
    emit(jump_zero_pop(8'd14));
    wp = 14;
    emit(push_imm(8'h02));
    emit(push_imm(8'h01));
    emit(alu_op(stack_cpu_pkg::alu_lt));
    emit(jump_zero_pop(8'd2));
    release_reset();
    wait_halt();
    assert (halt_pc == 10'd18) else report_mismatch("halt pc", 18, halt_pc);

    // ram, invalid and reserved addresses
    hold_reset();
    for (int k = 0; k < 5; k++) begin
      emit(push_imm(8'(8'h11 * (k + 1))));
      emit(store_top(addrs[k]));
    end
    emit(push_imm(8'hAA));
    for (int k = 5; k < 8; k++) begin
      emit(store_top(addrs[k]));
    end
    for (int k = 0; k < 8; k++) begin
      emit(load_push(addrs[k]));
      emit_send_top();
      exp_q.push_back(k < 5 ? 8'(8'h11 * (k + 1)) : 8'h00);
    end
    release_reset();
    wait_halt();
    check_frames();

    // receive path
    hold_reset();
    a = $random(seed);
    emit_poll_zero(`ADDR_RX_EMPTY);
    emit(load_push(`ADDR_UART_DATA));
    emit(push_imm(8'h35));
    emit(alu_op(stack_cpu_pkg::alu_add));
    emit_send_top();
    emit(load_push(`ADDR_RX_EMPTY));
    emit_send_top();
    exp_q.push_back(8'(a + 8'h35));
    exp_q.push_back(8'h01);
    release_reset();
    repeat (4 * B) @(posedge clk);
    send_byte(a);
    wait_halt();
    check_frames();

    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
